// ==== verilog/pma_pkg.sv ====
`default_nettype none

package pma_pkg;

  ////////////////////////////////////////////////////////////
  // region attribute encodings
  ////////////////////////////////////////////////////////////

  // what sits behind a region
  typedef enum logic [1:0] {
    MEM_TYPE_EMPTY = 2'b00,
    MEM_TYPE_MAIN  = 2'b01,
    MEM_TYPE_IO    = 2'b10
  } mem_type_t;

  // address matching mode, same encoding as the pmpcfg A field
  typedef enum logic [1:0] {
    OFF   = 2'b00,
    TOR   = 2'b01,
    NA4   = 2'b10,
    NAPOT = 2'b11
  } match_mode_t;

  // one region configuration record
  typedef struct packed {
    mem_type_t   mem_type;
    match_mode_t a;
    // access permissions
    logic        r;
    logic        w;
    logic        x;
    // cacheable and cache coherent
    logic        c;
    logic        cc;
    // read and write idempotent
    logic        ri;
    logic        wi;
    // misaligned accesses allowed
    logic        m;
  } pmacfg_t;

  ////////////////////////////////////////////////////////////
  // bus transfer size
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    BYTE  = 3'd0,
    HWORD = 3'd1,
    WORD  = 3'd2,
    DWORD = 3'd3,
    QWORD = 3'd4
  } biu_size_t;

  // number of bytes moved by one transfer
  function automatic logic [4:0] size2bytes(input biu_size_t size);
    logic [4:0] bytes;
    case (size)
      BYTE    : bytes = 5'd1;
      HWORD   : bytes = 5'd2;
      WORD    : bytes = 5'd4;
      DWORD   : bytes = 5'd8;
      QWORD   : bytes = 5'd16;
      // codes above QWORD are illegal
      default : bytes = 5'd0;
    endcase
    return bytes;
  endfunction

endpackage

`default_nettype wire

// ==== verilog/pma_region_if.sv ====
`default_nettype none

// decoded region table, decode stage to execute stage
interface pma_region_if #(
  parameter int PLEN    = 34,
  parameter int PMA_CNT = 8
);

  // bounds are word addresses, lower inclusive, upper exclusive
  logic [PLEN-1:2]  lb  [PMA_CNT];
  logic [PLEN-1:2]  ub  [PMA_CNT];
  // region takes part in matching (mode is not OFF)
  logic [PMA_CNT-1:0] en;
  // cleaned configuration records
  pma_pkg::pmacfg_t cfg [PMA_CNT];

  modport source (
    output lb,
    output ub,
    output en,
    output cfg
  );

  modport sink (
    input  lb,
    input  ub,
    input  en,
    input  cfg
  );

endinterface

`default_nettype wire

// ==== verilog/pma_match_if.sv ====
`default_nettype none

// registered match result, execute stage to result stage
interface pma_match_if #(
  parameter int PMA_CNT = 8
);

  // one bit per region, set when every byte of the access is inside
  logic [PMA_CNT-1:0] match_all;
  // access flags aligned with match_all
  logic               instruction;
  logic               we;
  logic               misaligned;
  // stage holds a real access
  logic               valid;

  modport source (
    output match_all,
    output instruction,
    output we,
    output misaligned,
    output valid
  );

  modport sink (
    input  match_all,
    input  instruction,
    input  we,
    input  misaligned,
    input  valid
  );

endinterface

`default_nettype wire

// ==== verilog/pma_region_decode.sv ====
`default_nettype none

// combinational region table decode
// the table is quasi static so no pipelining here
module pma_region_decode #(
  parameter int PLEN    = 34,
  parameter int PMA_CNT = 8,
  parameter int ADR_W   = 32
)
(
  input  pma_pkg::pmacfg_t   pma_cfg_i [PMA_CNT],
  input  logic [ADR_W-1:0]   pma_adr_i [PMA_CNT],
  pma_region_if.source       region
);

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // fix up attributes that make no sense for the memory type
  function automatic pma_pkg::pmacfg_t clean_cfg(input pma_pkg::pmacfg_t raw);
    pma_pkg::pmacfg_t cfg;
    cfg = raw;
    // empty region behaves as I/O with no access rights
    if (raw.mem_type == pma_pkg::MEM_TYPE_EMPTY)
    begin
      cfg.mem_type = pma_pkg::MEM_TYPE_IO;
      cfg.r        = 1'b0;
      cfg.w        = 1'b0;
      cfg.x        = 1'b0;
    end
    // only main memory can be cached
    cfg.c  = raw.c & (raw.mem_type == pma_pkg::MEM_TYPE_MAIN);
    cfg.cc = raw.cc & cfg.c;
    // anything but I/O is idempotent
    if (raw.mem_type != pma_pkg::MEM_TYPE_IO)
    begin
      cfg.ri = 1'b1;
      cfg.wi = 1'b1;
    end
    return cfg;
  endfunction

  // address mask for NA4/NAPOT
  // napot clears the trailing ones plus the first zero above them
  function automatic logic [PLEN-1:2] napot_mask(
    input logic            na4,
    input logic [PLEN-1:2] word
  );
    logic [PLEN-1:2] mask;
    logic            run;
    mask = '1;
    run  = ~na4;
    for (int b = 2; b < PLEN; b++)
    begin
      if (run)
        mask[b] = 1'b0;
      run = run & word[b];
    end
    return mask;
  endfunction

  ////////////////////////////////////////////////////////////
  // per region decode
  ////////////////////////////////////////////////////////////

  pma_pkg::pmacfg_t cfg      [PMA_CNT];
  logic [PLEN-1:2]  word     [PMA_CNT];
  logic [PLEN-1:2]  mask     [PMA_CNT];
  logic [PLEN-1:2]  napot_lb [PMA_CNT];
  logic [PLEN-1:2]  napot_ub [PMA_CNT];
  logic [PLEN-1:2]  tor_lb   [PMA_CNT];
  logic [PLEN-1:2]  lb       [PMA_CNT];
  logic [PLEN-1:2]  ub       [PMA_CNT];

  for (genvar i = 0; i < PMA_CNT; i++)
  begin : gen_region
    assign cfg[i]  = clean_cfg(pma_cfg_i[i]);
    // address word holds physical address bits PLEN-1:2
    assign word[i] = pma_adr_i[i][PLEN-3:0];

    assign mask[i]     = napot_mask(cfg[i].a == pma_pkg::NA4, word[i]);
    assign napot_lb[i] = word[i] & mask[i];
    // subtracting the mask adds the region size
    assign napot_ub[i] = napot_lb[i] - mask[i];

    // TOR starts where the previous region ends
    // a TOR or OFF predecessor ends at its own address word
    if (i == 0)
    begin : gen_first
      assign tor_lb[i] = '0;
    end
    else
    begin : gen_next
      assign tor_lb[i] = ub[i-1];
    end

    // OFF collapses to an empty range at its own word
    // so a TOR behind it still starts at that word
    assign lb[i] = (cfg[i].a == pma_pkg::TOR) ? tor_lb[i] :
                   (cfg[i].a == pma_pkg::OFF) ? word[i]   : napot_lb[i];
    assign ub[i] = (cfg[i].a == pma_pkg::TOR || cfg[i].a == pma_pkg::OFF) ? word[i]
                                                                         : napot_ub[i];

    assign region.lb[i]  = lb[i];
    assign region.ub[i]  = ub[i];
    assign region.en[i]  = cfg[i].a != pma_pkg::OFF;
    assign region.cfg[i] = cfg[i];

    // a TOR word below its predecessor gives an inverted range
    a_bounds_order : assert final (!region.en[i] || region.ub[i] >= region.lb[i])
      else $error("region %0d upper bound below lower bound", i);
  end

endmodule

`default_nettype wire

// ==== verilog/pma_range_execute.sv ====
`default_nettype none

// byte range check against every region, one register stage
module pma_range_execute #(
  parameter int PLEN    = 34,
  parameter int PMA_CNT = 8
)
(
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                stall_i,

  // physical access
  input  logic                instruction_i,
  input  logic [PLEN-1:0]     adr_i,
  input  pma_pkg::biu_size_t  size_i,
  input  logic                we_i,
  input  logic                misaligned_i,

  pma_region_if.sink          region,
  pma_match_if.source         match
);

  ////////////////////////////////////////////////////////////
  // access byte range
  ////////////////////////////////////////////////////////////

  logic [PLEN-1:0]    access_lb;
  logic [PLEN-1:0]    access_ub;
  logic [PMA_CNT-1:0] match_all;

  // first and last byte touched by the access
  assign access_lb = adr_i;
  assign access_ub = adr_i + PLEN'(pma_pkg::size2bytes(size_i)) - PLEN'(1);

  ////////////////////////////////////////////////////////////
  // region compare
  ////////////////////////////////////////////////////////////

  // every byte inside: lower bound inclusive, upper exclusive
  for (genvar i = 0; i < PMA_CNT; i++)
  begin : gen_match
    assign match_all[i] = region.en[i]
                        & (access_lb[PLEN-1:2] >= region.lb[i])
                        & (access_ub[PLEN-1:2] <  region.ub[i]);
  end

  ////////////////////////////////////////////////////////////
  // stage registers
  ////////////////////////////////////////////////////////////

  // valid rises on the first non stalled edge out of reset
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      match.valid <= 1'b0;
    else if (!stall_i)
      match.valid <= 1'b1;
  end

  // payload, frozen while stalled
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      match.match_all   <= match_all;
      match.instruction <= instruction_i;
      match.we          <= we_i;
      match.misaligned  <= misaligned_i;
    end
  end

  // the byte count only exists up to a quadword
  a_size_legal : assert property (
    @(posedge clk_i) disable iff (reset_i)
    !stall_i |-> size_i <= pma_pkg::QWORD
  ) else $error("illegal transfer size %0d", size_i);

endmodule

`default_nettype wire

// ==== verilog/pma_check_result.sv ====
`default_nettype none

// picks the winning region and forms the checker outputs
module pma_check_result #(
  parameter int PLEN    = 34,
  parameter int PMA_CNT = 8
)
(
  pma_match_if.sink   match,
  pma_region_if.sink  region,

  output logic        exception_o,
  output logic        misaligned_o,
  output logic        cacheable_o
);

  pma_pkg::pmacfg_t sel_cfg;
  logic             any_match;
  logic             hit;
  logic             is_read;

  ////////////////////////////////////////////////////////////
  // priority select
  ////////////////////////////////////////////////////////////

  // lowest index wins so scan downwards and let it overwrite
  always_comb
  begin
    sel_cfg = region.cfg[0];
    for (int n = PMA_CNT - 1; n >= 0; n--)
    begin
      if (match.match_all[n])
        sel_cfg = region.cfg[n];
    end
  end

  assign any_match = |match.match_all;
  assign hit       = match.valid & any_match;
  // a data load is neither a store nor a fetch
  assign is_read   = ~match.we & ~match.instruction;

  ////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////

  // no region at all or a region without the needed right
  assign exception_o = match.valid & (~any_match
                                      | (match.instruction & ~sel_cfg.x)
                                      | (match.we          & ~sel_cfg.w)
                                      | (is_read           & ~sel_cfg.r));

  // region may absorb misaligned accesses itself
  assign misaligned_o = hit & match.misaligned & ~sel_cfg.m;

  // cacheable already implies main memory after cleaning
  assign cacheable_o  = hit & sel_cfg.c;

  // the table stays put while a captured match is still in use
  a_match_enabled : assert final (match.valid !== 1'b1
                                  || (match.match_all & ~region.en) == '0)
    else $error("captured match on a region that is no longer enabled");

endmodule

`default_nettype wire

// ==== verilog/pma_checker.sv ====
`default_nettype none

// physical memory attributes checker, one cycle latency
module pma_checker #(
  parameter int PLEN    = 34,
  parameter int PMA_CNT = 8,
  parameter int ADR_W   = 32
)
(
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                stall_i,

  // region table
  input  pma_pkg::pmacfg_t    pma_cfg_i [PMA_CNT],
  input  logic [ADR_W-1:0]    pma_adr_i [PMA_CNT],

  // physical access
  input  logic                instruction_i,
  input  logic [PLEN-1:0]     adr_i,
  input  pma_pkg::biu_size_t  size_i,
  input  logic                we_i,
  input  logic                misaligned_i,

  // check result
  output logic                exception_o,
  output logic                misaligned_o,
  output logic                cacheable_o
);

  pma_region_if #(.PLEN(PLEN), .PMA_CNT(PMA_CNT)) region_bus ();
  pma_match_if  #(.PMA_CNT(PMA_CNT))              match_bus ();

  ////////////////////////////////////////////////////////////
  // stages
  ////////////////////////////////////////////////////////////

  // bounds and cleaned attributes
  pma_region_decode #(.PLEN(PLEN), .PMA_CNT(PMA_CNT), .ADR_W(ADR_W)) decode0 (
    .pma_cfg_i     (pma_cfg_i),
    .pma_adr_i     (pma_adr_i),
    .region        (region_bus.source)
  );

  // registered range match
  pma_range_execute #(.PLEN(PLEN), .PMA_CNT(PMA_CNT)) execute0 (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .stall_i       (stall_i),
    .instruction_i (instruction_i),
    .adr_i         (adr_i),
    .size_i        (size_i),
    .we_i          (we_i),
    .misaligned_i  (misaligned_i),
    .region        (region_bus.sink),
    .match         (match_bus.source)
  );

  // priority select and outputs
  pma_check_result #(.PLEN(PLEN), .PMA_CNT(PMA_CNT)) result0 (
    .match         (match_bus.sink),
    .region        (region_bus.sink),
    .exception_o   (exception_o),
    .misaligned_o  (misaligned_o),
    .cacheable_o   (cacheable_o)
  );

endmodule

`default_nettype wire

// ==== tb/pma_checker_tb.sv ====
`default_nettype none

module pma_checker_tb;

  localparam int PLEN          = 34;
  localparam int PMA_CNT       = 8;
  localparam int ADR_W         = 32;
  localparam int NUM_ROWS      = 18;
  localparam int RESET_TIMEOUT = 10;

  logic                clk_i;
  logic                reset_i;
  logic                stall_i;
  pma_pkg::pmacfg_t    pma_cfg_i [PMA_CNT];
  logic [ADR_W-1:0]    pma_adr_i [PMA_CNT];
  logic                instruction_i;
  logic [PLEN-1:0]     adr_i;
  pma_pkg::biu_size_t  size_i;
  logic                we_i;
  logic                misaligned_i;
  logic                exception_o;
  logic                misaligned_o;
  logic                cacheable_o;

  // stimulus table, one entry per access
  string               row_name    [NUM_ROWS];
  logic                row_instr   [NUM_ROWS];
  logic                row_we      [NUM_ROWS];
  logic                row_mis     [NUM_ROWS];
  logic [PLEN-1:0]     row_adr     [NUM_ROWS];
  pma_pkg::biu_size_t  row_size    [NUM_ROWS];
  logic                row_exc     [NUM_ROWS];
  logic                row_mis_exp [NUM_ROWS];
  logic                row_cache   [NUM_ROWS];
  int                  row_count;
  int                  failures;

  pma_checker #(.PLEN(PLEN), .PMA_CNT(PMA_CNT), .ADR_W(ADR_W)) dut0 (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .stall_i       (stall_i),
    .pma_cfg_i     (pma_cfg_i),
    .pma_adr_i     (pma_adr_i),
    .instruction_i (instruction_i),
    .adr_i         (adr_i),
    .size_i        (size_i),
    .we_i          (we_i),
    .misaligned_i  (misaligned_i),
    .exception_o   (exception_o),
    .misaligned_o  (misaligned_o),
    .cacheable_o   (cacheable_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // raw region record, coherence and idempotent bits left clear
  function automatic pma_pkg::pmacfg_t region_cfg(
    input pma_pkg::mem_type_t   mem,
    input pma_pkg::match_mode_t mode,
    input logic                 r,
    input logic                 w,
    input logic                 x,
    input logic                 c,
    input logic                 m
  );
    pma_pkg::pmacfg_t cfg;
    cfg          = '0;
    cfg.mem_type = mem;
    cfg.a        = mode;
    cfg.r        = r;
    cfg.w        = w;
    cfg.x        = x;
    cfg.c        = c;
    cfg.m        = m;
    return cfg;
  endfunction

  task automatic add_row(
    input string              name,
    input logic               instr,
    input logic               we,
    input logic               mis,
    input logic [PLEN-1:0]    adr,
    input pma_pkg::biu_size_t size,
    input logic               exc,
    input logic               mis_exp,
    input logic               cache
  );
    row_name[row_count]    = name;
    row_instr[row_count]   = instr;
    row_we[row_count]      = we;
    row_mis[row_count]     = mis;
    row_adr[row_count]     = adr;
    row_size[row_count]    = size;
    row_exc[row_count]     = exc;
    row_mis_exp[row_count] = mis_exp;
    row_cache[row_count]   = cache;
    row_count++;
  endtask

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic expect_equal(
    input string       test_name,
    input string       signal_name,
    input logic [31:0] expected,
    input logic [31:0] actual
  );
    if (actual !== expected)
    begin
      failures++;
      $display("Error: %s %s expected %0h actual %0h", test_name, signal_name,
               expected, actual);
      abort_run();
    end
  endtask

  task automatic drive_row(input int k);
    instruction_i = row_instr[k];
    we_i          = row_we[k];
    misaligned_i  = row_mis[k];
    adr_i         = row_adr[k];
    size_i        = row_size[k];
  endtask

  task automatic check_outputs(
    input string name,
    input logic  exc,
    input logic  mis,
    input logic  cache
  );
    expect_equal(name, "exception_o", 32'(exc), 32'(exception_o));
    expect_equal(name, "misaligned_o", 32'(mis), 32'(misaligned_o));
    expect_equal(name, "cacheable_o", 32'(cache), 32'(cacheable_o));
  endtask

  task automatic check_row(input int k);
    check_outputs(row_name[k], row_exc[k], row_mis_exp[k], row_cache[k]);
  endtask

  ////////////////////////////////////////////////////////////
  // region map and table
  ////////////////////////////////////////////////////////////

  initial
  begin
    int cycles;

    // region 0: 4 KiB napot main memory at 0x0
    pma_cfg_i[0] = region_cfg(pma_pkg::MEM_TYPE_MAIN, pma_pkg::NAPOT, 1, 1, 1, 1, 1);
    pma_adr_i[0] = 32'h0000_01ff;
    // region 1: tor I/O from the end of region 0 up to 0x2000
    pma_cfg_i[1] = region_cfg(pma_pkg::MEM_TYPE_IO, pma_pkg::TOR, 1, 1, 0, 0, 0);
    pma_adr_i[1] = 32'h0000_0800;
    // region 2: read only word at 0x3000
    pma_cfg_i[2] = region_cfg(pma_pkg::MEM_TYPE_MAIN, pma_pkg::NA4, 1, 0, 0, 0, 0);
    pma_adr_i[2] = 32'h0000_0c00;
    // region 3: 64 KiB napot empty type at 0x0, overlaps 0 to 2
    pma_cfg_i[3] = region_cfg(pma_pkg::MEM_TYPE_EMPTY, pma_pkg::NAPOT, 1, 1, 1, 0, 0);
    pma_adr_i[3] = 32'h0000_1fff;
    for (int i = 4; i < PMA_CNT; i++)
    begin
      pma_cfg_i[i] = '0;
      pma_adr_i[i] = '0;
    end

    row_count = 0;
    failures  = 0;
    //      name                    ins we mis address         size            exc mis c
    add_row("outside_all",          0, 0, 0, 34'h0_0002_0000, pma_pkg::WORD,  1, 0, 0);
    add_row("fetch_tor_io",         1, 0, 0, 34'h0_0000_1100, pma_pkg::WORD,  1, 0, 0);
    add_row("write_tor_io",         0, 1, 0, 34'h0_0000_1200, pma_pkg::WORD,  0, 0, 0);
    add_row("write_na4_ro",         0, 1, 0, 34'h0_0000_3000, pma_pkg::WORD,  1, 0, 0);
    add_row("read_na4_ro",          0, 0, 0, 34'h0_0000_3000, pma_pkg::WORD,  0, 0, 0);
    add_row("napot_last_word",      0, 0, 0, 34'h0_0000_0ffc, pma_pkg::WORD,  0, 0, 1);
    add_row("napot_upper_straddle", 0, 0, 1, 34'h0_0000_0ffc, pma_pkg::DWORD, 1, 1, 0);
    add_row("qword_in_main",        0, 0, 0, 34'h0_0000_0ff0, pma_pkg::QWORD, 0, 0, 1);
    add_row("tor_lower_edge",       0, 0, 0, 34'h0_0000_1000, pma_pkg::WORD,  0, 0, 0);
    add_row("tor_lower_straddle",   0, 0, 1, 34'h0_0000_0fff, pma_pkg::HWORD, 1, 1, 0);
    add_row("tor_upper_word",       0, 0, 0, 34'h0_0000_1ffc, pma_pkg::WORD,  0, 0, 0);
    add_row("tor_upper_straddle",   0, 0, 1, 34'h0_0000_1ffc, pma_pkg::DWORD, 1, 1, 0);
    add_row("misaligned_io",        0, 0, 1, 34'h0_0000_1102, pma_pkg::WORD,  0, 1, 0);
    add_row("aligned_io",           0, 0, 0, 34'h0_0000_1104, pma_pkg::WORD,  0, 0, 0);
    add_row("misaligned_main",      0, 0, 1, 34'h0_0000_0102, pma_pkg::WORD,  0, 0, 1);
    add_row("empty_type_read",      0, 0, 0, 34'h0_0000_8000, pma_pkg::WORD,  1, 0, 0);
    add_row("priority_fetch",       1, 0, 0, 34'h0_0000_0200, pma_pkg::WORD,  0, 0, 1);
    add_row("priority_read",        0, 0, 0, 34'h0_0000_0100, pma_pkg::WORD,  0, 0, 1);

    // first row already on the bus, held off by stall
    reset_i = 1'b1;
    stall_i = 1'b1;
    drive_row(0);

    ////////////////////////////////////////////////////////////
    // reset
    ////////////////////////////////////////////////////////////

    repeat (3) @(posedge clk_i);
    #2 reset_i = 1'b0;

    // outputs must settle low once reset has cleared the stage
    cycles = 0;
    while ((exception_o !== 1'b0 || misaligned_o !== 1'b0 || cacheable_o !== 1'b0)
           && cycles < RESET_TIMEOUT)
    begin
      @(posedge clk_i);
      #2 cycles++;
    end
    if (cycles >= RESET_TIMEOUT)
    begin
      $display("Error: timeout, outputs did not go low after reset release");
      abort_run();
    end

    // still stalled, nothing captured yet
    repeat (2)
    begin
      @(posedge clk_i);
      #2 check_outputs("stalled_after_reset", 0, 0, 0);
    end

    ////////////////////////////////////////////////////////////
    // streamed table, one access per cycle
    ////////////////////////////////////////////////////////////

    stall_i = 1'b0;
    for (int k = 1; k < NUM_ROWS; k++)
    begin
      @(posedge clk_i);
      // result of row k-1 is registered, then the next row goes out
      #2 check_row(k - 1);
      drive_row(k);
    end
    @(posedge clk_i);
    #2 check_row(NUM_ROWS - 1);

    ////////////////////////////////////////////////////////////
    // stall holds the last result
    ////////////////////////////////////////////////////////////

    stall_i = 1'b1;
    drive_row(0);
    repeat (2)
    begin
      @(posedge clk_i);
      #2 check_outputs("stall_hold", row_exc[NUM_ROWS - 1], row_mis_exp[NUM_ROWS - 1],
                       row_cache[NUM_ROWS - 1]);
    end
    stall_i = 1'b0;
    @(posedge clk_i);
    #2 check_outputs("stall_release", row_exc[0], row_mis_exp[0], row_cache[0]);

    if (failures == 0)
    begin
      $display("PASS: all tests");
      $finish;
    end
    else
    begin
      abort_run();
    end
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/pma_pkg.sv
verilog/pma_region_if.sv
verilog/pma_match_if.sv
verilog/pma_region_decode.sv
verilog/pma_range_execute.sv
verilog/pma_check_result.sv
verilog/pma_checker.sv
tb/pma_checker_tb.sv

// ==== Bender.yml ====
package:
  name: pma_checker

sources:
  # package and interfaces first
  - verilog/pma_pkg.sv
  - verilog/pma_region_if.sv
  - verilog/pma_match_if.sv
  # pipeline stages and top level
  - verilog/pma_region_decode.sv
  - verilog/pma_range_execute.sv
  - verilog/pma_check_result.sv
  - verilog/pma_checker.sv
  # testbench
  - target: simulation
    files:
      - tb/pma_checker_tb.sv
